// File: common/tlk2711_rx_pkg.sv
//////////////////////////////////////////////////////////////////////
// tlk2711 receive framer definitions
// link code words, framer states and the word, header and status
// types used across the receive path
//////////////////////////////////////////////////////////////////////

package tlk2711_rx_pkg;

    //////////////////////////////////////////////////////////////////////
    // link code words
    //////////////////////////////////////////////////////////////////////

    // sync, D5.6 high byte over K28.5 low byte, only the low K flag set
    localparam logic [15:0] k_sync_word = 16'hC5BC;

    // start of frame, K28.2 high over K27.7 low, both K flags set
    localparam logic [15:0] k_sof_word = 16'h5CFB;

    // head flag spans two consecutive data words
    localparam logic [31:0] k_frame_head_flag = 32'hEB90_E116;

    // all ones with both K flags means the link is gone
    localparam logic [15:0] k_link_loss_word = 16'hFFFF;

    //////////////////////////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////////////////////////

    // one received word as delivered by the serdes
    typedef struct packed {
        logic        kmsb;
        logic        klsb;
        logic [15:0] data;
    } tlk_word_t;

    typedef enum logic [3:0] {
        IDLE        = 4'd0,
        SYNC        = 4'd1,
        FRAME_HEAD  = 4'd2,
        DATA_TYPE   = 4'd3,
        LINE_INFO   = 4'd4,
        DATA_LENGTH = 4'd5,
        RECV_DATA   = 4'd6,
        CHECK_DATA  = 4'd7,
        FRAME_END1  = 4'd8,
        FRAME_END2  = 4'd9
    } rx_state_e;

    // first header word, summed as a whole or split into fields
    typedef union packed {
        logic [15:0] raw;
        struct packed {
            logic [1:0] file_end;
            logic [1:0] channel_id;
            logic [3:0] data_type;
            logic [7:0] line_hi;
        } fields;
    } rx_type_word_u;

    typedef struct packed {
        logic [1:0]  file_end;
        logic [1:0]  channel_id;
        logic [3:0]  data_type;
        logic [23:0] line_number;
        logic [15:0] data_length;
    } rx_header_t;

    typedef struct packed {
        logic        valid;
        logic        last;
        logic [15:0] data;
    } rx_payload_t;

    typedef struct packed {
        logic done;
        logic checksum_err;
    } rx_frame_result_t;

    typedef struct packed {
        logic link_loss;
        logic sync_loss;
    } rx_loss_t;

endpackage

// File: src/rx_frame_fsm.sv
//////////////////////////////////////////////////////////////////////
// receive frame FSM
// walks from sync hunt through header, payload and checksum to the
// two frame end cycles
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module rx_frame_fsm (
    input  logic                      i_2711_rx_clk,
    input  logic                      i_rst_n,
    input  tlk2711_rx_pkg::tlk_word_t i_word,
    input  logic                      i_last_word,
    output tlk2711_rx_pkg::rx_state_e o_state
);

    import tlk2711_rx_pkg::*;

    rx_state_e   state_q;
    rx_state_e   state_d;
    logic [15:0] prev_data;

    assign o_state = state_q;

    // previous word, high half of the head flag
    always_ff @(posedge i_2711_rx_clk) begin
        prev_data <= i_word.data;
    end

    always_ff @(posedge i_2711_rx_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (!i_word.kmsb && i_word.klsb && i_word.data == k_sync_word) begin
                    state_d = SYNC;
                end
            end
            SYNC: begin
                if (i_word.kmsb && i_word.klsb && i_word.data == k_sof_word) begin
                    state_d = FRAME_HEAD;
                end
            end
            FRAME_HEAD: begin
                if ({prev_data, i_word.data} == k_frame_head_flag) begin
                    state_d = DATA_TYPE;
                end
            end
            // header words, one cycle each
            DATA_TYPE:   state_d = LINE_INFO;
            LINE_INFO:   state_d = DATA_LENGTH;
            DATA_LENGTH: state_d = RECV_DATA;
            RECV_DATA: begin
                if (i_last_word) begin
                    state_d = CHECK_DATA;
                end
            end
            CHECK_DATA:  state_d = FRAME_END1;
            FRAME_END1:  state_d = FRAME_END2;
            FRAME_END2:  state_d = IDLE;
            // illegal encoding falls back to sync hunt
            default:     state_d = IDLE;
        endcase
    end

    a_state_legal: assert property (@(posedge i_2711_rx_clk) disable iff (!i_rst_n)
        state_q inside {IDLE, SYNC, FRAME_HEAD, DATA_TYPE, LINE_INFO, DATA_LENGTH,
                        RECV_DATA, CHECK_DATA, FRAME_END1, FRAME_END2});

endmodule

// File: src/rx_payload_counter.sv
//////////////////////////////////////////////////////////////////////
// payload word counter
// flags the final payload word from the frame length and its unit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module rx_payload_counter (
    input  logic                      i_2711_rx_clk,
    input  logic                      i_rst_n,
    input  tlk2711_rx_pkg::rx_state_e i_state,
    input  logic [15:0]               i_data_length,
    input  logic                      i_rx_length_unit,
    output logic                      o_last_word
);

    import tlk2711_rx_pkg::*;

    logic [15:0] word_count;
    logic [15:0] recv_count;

    // byte lengths round up to whole 16-bit words
    assign word_count = i_rx_length_unit
                      ? i_data_length
                      : {1'b0, i_data_length[15:1]} + {15'd0, i_data_length[0]};

    always_ff @(posedge i_2711_rx_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            recv_count <= '0;
        end else if (i_state == RECV_DATA) begin
            recv_count <= recv_count + 16'd1;
        end else begin
            recv_count <= '0;
        end
    end

    // length of zero is not a legal frame
    assign o_last_word = (i_state == RECV_DATA) && (recv_count == word_count - 16'd1);

endmodule

// File: src/rx_frame_capture.sv
//////////////////////////////////////////////////////////////////////
// frame capture
// decodes the three header words, forwards payload words and checks
// the additive checksum of each frame
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module rx_frame_capture (
    input  logic                             i_2711_rx_clk,
    input  logic                             i_rst_n,
    input  tlk2711_rx_pkg::rx_state_e        i_state,
    input  tlk2711_rx_pkg::tlk_word_t        i_word,
    output tlk2711_rx_pkg::rx_header_t       o_header,
    output logic [15:0]                      o_data_length,
    output tlk2711_rx_pkg::rx_payload_t      o_payload,
    output tlk2711_rx_pkg::rx_frame_result_t o_frame_result
);

    import tlk2711_rx_pkg::*;

    rx_type_word_u type_word;
    rx_type_word_u type_q;
    logic [15:0]   line_lo_q;
    rx_header_t    header_q;
    logic          payload_valid;
    logic [15:0]   payload_data;
    logic [15:0]   checksum;
    logic          checksum_err;
    logic          done;

    assign type_word.raw = i_word.data;

    //////////////////////////////////////////////////////////////////////
    // header
    //////////////////////////////////////////////////////////////////////

    // staged until the length word so the header changes in one step
    always_ff @(posedge i_2711_rx_clk) begin
        if (i_state == DATA_TYPE) begin
            type_q <= type_word;
        end
        if (i_state == LINE_INFO) begin
            line_lo_q <= i_word.data;
        end
    end

    always_ff @(posedge i_2711_rx_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            header_q <= '0;
        end else if (i_state == DATA_LENGTH) begin
            header_q <= '{file_end:    type_q.fields.file_end,
                          channel_id:  type_q.fields.channel_id,
                          data_type:   type_q.fields.data_type,
                          line_number: {type_q.fields.line_hi, line_lo_q},
                          data_length: i_word.data};
        end
    end

    assign o_header      = header_q;
    assign o_data_length = header_q.data_length;

    //////////////////////////////////////////////////////////////////////
    // payload and checksum
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_2711_rx_clk) begin
        payload_data <= i_word.data;
    end

    always_ff @(posedge i_2711_rx_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            payload_valid <= 1'b0;
            checksum      <= '0;
            checksum_err  <= 1'b0;
            done          <= 1'b0;
        end else begin
            payload_valid <= (i_state == RECV_DATA);
            done          <= (i_state == CHECK_DATA);
            case (i_state)
                // type word opens the sum, error from the last frame drops
                DATA_TYPE: begin
                    checksum     <= type_word.raw;
                    checksum_err <= 1'b0;
                end
                LINE_INFO, DATA_LENGTH, RECV_DATA: begin
                    checksum <= checksum + i_word.data;
                end
                CHECK_DATA: begin
                    checksum_err <= (checksum != i_word.data);
                end
                default: begin
                    checksum <= checksum;
                end
            endcase
        end
    end

    // last word is out once the FSM has moved on to the checksum
    assign o_payload = '{valid: payload_valid,
                         last:  payload_valid && (i_state == CHECK_DATA),
                         data:  payload_data};

    assign o_frame_result = '{done: done, checksum_err: checksum_err};

endmodule

// File: src/rx_loss_monitor.sv
//////////////////////////////////////////////////////////////////////
// loss monitor
// one-cycle link-loss and sync-loss pulses, each followed by a
// holdoff window that keeps the host from being flooded
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module rx_loss_monitor #(
    parameter int unsigned p_holdoff_cycles = 10_000_000
) (
    input  logic                      i_2711_rx_clk,
    input  logic                      i_rst_n,
    input  tlk2711_rx_pkg::tlk_word_t i_word,
    input  tlk2711_rx_pkg::rx_state_e i_state,
    input  logic                      i_link_loss_detect_ena,
    input  logic                      i_sync_loss_detect_ena,
    output tlk2711_rx_pkg::rx_loss_t  o_loss
);

    import tlk2711_rx_pkg::*;

    // index 0 is link loss, index 1 is sync loss
    logic [1:0] hit;
    logic [1:0] ena;
    logic [1:0] pulse;

    assign hit[0] = i_word.kmsb && i_word.klsb && (i_word.data == k_link_loss_word);

    // any K character inside a frame body means lost alignment
    assign hit[1] = (i_word.kmsb || i_word.klsb) &&
                    (i_state inside {DATA_TYPE, LINE_INFO, DATA_LENGTH,
                                     RECV_DATA, CHECK_DATA});

    assign ena = {i_sync_loss_detect_ena, i_link_loss_detect_ena};

    for (genvar g = 0; g < 2; g++) begin : g_det
        logic        pulse_q;
        logic        holdoff_q;
        logic [23:0] timer_q;

        always_ff @(posedge i_2711_rx_clk or negedge i_rst_n) begin
            if (!i_rst_n) begin
                pulse_q   <= 1'b0;
                holdoff_q <= 1'b0;
                timer_q   <= '0;
            end else if (!ena[g]) begin
                pulse_q   <= 1'b0;
                holdoff_q <= 1'b0;
                timer_q   <= '0;
            end else begin
                pulse_q <= hit[g] && !holdoff_q && !pulse_q;
                if (pulse_q) begin
                    holdoff_q <= 1'b1;
                end else if (timer_q == 24'(p_holdoff_cycles - 1)) begin
                    holdoff_q <= 1'b0;
                end
                // window length counted only while held off
                if (holdoff_q) begin
                    timer_q <= timer_q + 24'd1;
                end else begin
                    timer_q <= '0;
                end
            end
        end

        assign pulse[g] = pulse_q;

        a_pulse_single: assert property (@(posedge i_2711_rx_clk) disable iff (!i_rst_n)
            pulse_q |=> !pulse_q);

        a_pulse_held: assert property (@(posedge i_2711_rx_clk) disable iff (!i_rst_n)
            holdoff_q |-> !pulse_q);
    end

    assign o_loss = '{link_loss: pulse[0], sync_loss: pulse[1]};

endmodule

// File: src/tlk2711_rx_link.sv
//////////////////////////////////////////////////////////////////////
// tlk2711 receive link
// frames the serdes word stream into header, payload and checksum
// result, and reports link and sync loss
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tlk2711_rx_link #(
    parameter int unsigned p_holdoff_cycles = 10_000_000
) (
    input  logic                            i_2711_rx_clk,
    input  logic                            i_rst_n,

    // serdes receive side
    input  logic                            i_2711_rkmsb,
    input  logic                            i_2711_rklsb,
    input  logic [15:0]                     i_2711_rxd,

    // per frame and detection controls
    input  logic                            i_rx_length_unit,
    input  logic                            i_link_loss_detect_ena,
    input  logic                            i_sync_loss_detect_ena,

    output tlk2711_rx_pkg::rx_header_t       o_header,
    output tlk2711_rx_pkg::rx_payload_t      o_payload,
    output tlk2711_rx_pkg::rx_frame_result_t o_frame_result,
    output tlk2711_rx_pkg::rx_loss_t         o_loss
);

    import tlk2711_rx_pkg::*;

    tlk_word_t   rx_word;
    rx_state_e   rx_state;
    logic [15:0] data_length;
    logic        last_word;

    assign rx_word = '{kmsb: i_2711_rkmsb, klsb: i_2711_rklsb, data: i_2711_rxd};

    rx_frame_fsm u_frame_fsm (
        .i_2711_rx_clk (i_2711_rx_clk),
        .i_rst_n       (i_rst_n),
        .i_word        (rx_word),
        .i_last_word   (last_word),
        .o_state       (rx_state)
    );

    // decides when RECV_DATA ends
    rx_payload_counter u_payload_counter (
        .i_2711_rx_clk    (i_2711_rx_clk),
        .i_rst_n          (i_rst_n),
        .i_state          (rx_state),
        .i_data_length    (data_length),
        .i_rx_length_unit (i_rx_length_unit),
        .o_last_word      (last_word)
    );

    rx_frame_capture u_frame_capture (
        .i_2711_rx_clk  (i_2711_rx_clk),
        .i_rst_n        (i_rst_n),
        .i_state        (rx_state),
        .i_word         (rx_word),
        .o_header       (o_header),
        .o_data_length  (data_length),
        .o_payload      (o_payload),
        .o_frame_result (o_frame_result)
    );

    rx_loss_monitor #(
        .p_holdoff_cycles (p_holdoff_cycles)
    ) u_loss_monitor (
        .i_2711_rx_clk          (i_2711_rx_clk),
        .i_rst_n                (i_rst_n),
        .i_word                 (rx_word),
        .i_state                (rx_state),
        .i_link_loss_detect_ena (i_link_loss_detect_ena),
        .i_sync_loss_detect_ena (i_sync_loss_detect_ena),
        .o_loss                 (o_loss)
    );

endmodule

// File: tb/tb_rx_frame_table.svh
//////////////////////////////////////////////////////////////////////
// frame table for the receive link testbench
// header fields, length unit, checksum corruption and gap per frame,
// with the K-flag and link-loss injections and the pulses they expect
//////////////////////////////////////////////////////////////////////

`ifndef TB_RX_FRAME_TABLE_SVH
`define TB_RX_FRAME_TABLE_SVH

typedef struct packed {
    logic [1:0]  file_end;
    logic [1:0]  channel_id;
    logic [3:0]  data_type;
    logic [23:0] line_number;
    logic [15:0] data_length;
    logic        unit;
    logic        corrupt;
    logic [7:0]  gap;
    logic        broken_head;
    // payload index that carries a K flag, FF for none
    logic [7:0]  k_at_a;
    logic        k_pulse_a;
    logic [7:0]  k_at_b;
    logic        k_pulse_b;
    logic        link_ena;
    // two link-loss words in the gap, four cycles apart
    logic        link_word;
    logic        link_pulse;
} frame_entry_t;

localparam int n_frames = 8;

// fe, ch, type, line, length, unit, corrupt, gap, broken head
// then k_at_a, pulse a, k_at_b, pulse b, link ena, link word, link pulse
localparam frame_entry_t frame_table [n_frames] = '{
    '{2'd0, 2'd1, 4'h3, 24'h000001, 16'd8, 1'b1, 1'b0, 8'd10, 1'b0,
      8'hFF, 1'b0, 8'hFF, 1'b0, 1'b0, 1'b0, 1'b0},
    '{2'd1, 2'd2, 4'hA, 24'h123456, 16'd13, 1'b0, 1'b0, 8'd12, 1'b0,
      8'hFF, 1'b0, 8'hFF, 1'b0, 1'b0, 1'b0, 1'b0},
    '{2'd2, 2'd0, 4'h5, 24'h00ABCD, 16'd20, 1'b0, 1'b1, 8'd10, 1'b0,
      8'hFF, 1'b0, 8'hFF, 1'b0, 1'b0, 1'b0, 1'b0},
    '{2'd3, 2'd3, 4'hF, 24'hFFFFFE, 16'd1, 1'b1, 1'b0, 8'd24, 1'b1,
      8'hFF, 1'b0, 8'hFF, 1'b0, 1'b0, 1'b0, 1'b0},
    '{2'd0, 2'd2, 4'h7, 24'hA50F0F, 16'd30, 1'b1, 1'b0, 8'd10, 1'b0,
      8'd3, 1'b1, 8'd20, 1'b0, 1'b0, 1'b0, 1'b0},
    '{2'd1, 2'd1, 4'h9, 24'h000100, 16'd6, 1'b1, 1'b0, 8'd80, 1'b0,
      8'd2, 1'b1, 8'hFF, 1'b0, 1'b0, 1'b0, 1'b0},
    '{2'd2, 2'd3, 4'hC, 24'h7FFF00, 16'd3, 1'b0, 1'b1, 8'd80, 1'b0,
      8'hFF, 1'b0, 8'hFF, 1'b0, 1'b1, 1'b1, 1'b1},
    '{2'd0, 2'd0, 4'h1, 24'h010203, 16'd5, 1'b1, 1'b0, 8'd12, 1'b0,
      8'hFF, 1'b0, 8'hFF, 1'b0, 1'b0, 1'b1, 1'b0}
};

`endif

// File: tb/tb_tlk2711_rx_link.sv
//////////////////////////////////////////////////////////////////////
// testbench for the tlk2711 receive link
// sends the frame table through the DUT and checks header, payload,
// checksum result and loss pulses
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_tlk2711_rx_link;

    import tlk2711_rx_pkg::*;

    `include "tb_rx_frame_table.svh"

    localparam int timeout_cycles = 2000;

    logic             rx_clk = 1'b0;
    logic             rst_n;
    logic             rkmsb;
    logic             rklsb;
    logic [15:0]      rxd;
    logic             length_unit;
    logic             link_ena;
    logic             sync_ena;
    rx_header_t       header;
    rx_payload_t      payload;
    rx_frame_result_t frame_result;
    rx_loss_t         loss;

    rx_payload_t      exp_q[$];
    rx_loss_t         loss_exp_drv;
    rx_loss_t         loss_exp_q;
    int               done_count;

    always #2 rx_clk = ~rx_clk;

    tlk2711_rx_link #(
        .p_holdoff_cycles (64)
    ) dut0 (
        .i_2711_rx_clk          (rx_clk),
        .i_rst_n                (rst_n),
        .i_2711_rkmsb           (rkmsb),
        .i_2711_rklsb           (rklsb),
        .i_2711_rxd             (rxd),
        .i_rx_length_unit       (length_unit),
        .i_link_loss_detect_ena (link_ena),
        .i_sync_loss_detect_ena (sync_ena),
        .o_header               (header),
        .o_payload              (payload),
        .o_frame_result         (frame_result),
        .o_loss                 (loss)
    );

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_header(input rx_header_t got, input rx_header_t want);
        if (got !== want) begin
            stop_with_failure($sformatf("error at %0t: header %h, expected %h",
                                        $time, got, want));
        end
    endtask

    task automatic check_payload(input rx_payload_t got, input rx_payload_t want);
        if (got !== want) begin
            stop_with_failure($sformatf("error at %0t: payload %h, expected %h",
                                        $time, got, want));
        end
    endtask

    task automatic check_result(input rx_frame_result_t got, input rx_frame_result_t want);
        if (got !== want) begin
            stop_with_failure($sformatf("error at %0t: frame result %b, expected %b",
                                        $time, got, want));
        end
    endtask

    task automatic check_loss(input rx_loss_t got, input rx_loss_t want);
        if (got !== want) begin
            stop_with_failure($sformatf("error at %0t: loss pulses %b, expected %b",
                                        $time, got, want));
        end
    endtask

    // one link word per rising edge, with the loss it should cause
    task automatic drive_word(input logic kmsb, input logic klsb, input logic [15:0] data,
                              input rx_loss_t exp_loss);
        @(posedge rx_clk);
        rkmsb        <= kmsb;
        rklsb        <= klsb;
        rxd          <= data;
        loss_exp_drv <= exp_loss;
    endtask

    task automatic drive_filler();
        drive_word(1'b0, 1'b0, 16'($urandom), '0);
    endtask

    task automatic wait_frame_done(output rx_frame_result_t res);
        int cycles;
        cycles = 0;
        res    = '0;
        while (!res.done) begin
            if (cycles >= timeout_cycles) begin
                stop_with_failure("timeout, the frame done pulse never came");
            end else begin
                drive_filler();
                @(negedge rx_clk);
                res    = frame_result;
                cycles = cycles + 1;
            end
        end
    endtask

    // expected loss lines up with the edge that samples the word
    always @(posedge rx_clk) begin
        loss_exp_q <= loss_exp_drv;
    end

    always @(negedge rx_clk) begin : watch_outputs
        rx_payload_t want;
        if (rst_n) begin
            check_loss(loss, loss_exp_q);
            if (payload.valid) begin
                if (exp_q.size() == 0) begin
                    stop_with_failure("a payload word came out with no frame payload pending");
                end else begin
                    want = exp_q.pop_front();
                    check_payload(payload, want);
                end
            end
            if (frame_result.done) begin
                done_count = done_count + 1;
            end
        end
    end

    initial begin : main_sequence
        frame_entry_t     e;
        rx_header_t       hdr_exp;
        rx_payload_t      word_exp;
        rx_frame_result_t res;
        logic [15:0]      type_word;
        logic [15:0]      n_words;
        logic [15:0]      sum;
        logic [15:0]      word;
        logic             prev_corrupt;

        void'($urandom(56180));
        rst_n        = 1'b0;
        rkmsb        = 1'b0;
        rklsb        = 1'b0;
        rxd          = '0;
        length_unit  = 1'b1;
        link_ena     = 1'b0;
        sync_ena     = 1'b1;
        loss_exp_drv = '0;
        loss_exp_q   = '0;
        done_count   = 0;
        prev_corrupt = 1'b0;

        repeat (2) @(posedge rx_clk);
        rst_n <= 1'b1;
        @(negedge rx_clk);
        check_header(header, '0);
        check_payload(payload, '0);
        check_result(frame_result, '0);

        for (int i = 0; i < n_frames; i++) begin
            e = frame_table[i];
            // let the previous frame run out its end states
            drive_filler();
            length_unit <= e.unit;
            link_ena    <= e.link_ena;
            drive_filler();
            @(negedge rx_clk);
            if (done_count != i) begin
                stop_with_failure("frame done pulsed outside the expected frame end");
            end
            check_result(frame_result,
                         rx_frame_result_t'{done: 1'b0, checksum_err: prev_corrupt});

            // head flag with its last bit flipped
            if (e.broken_head) begin
                drive_word(1'b0, 1'b1, k_sync_word, '0);
                drive_word(1'b1, 1'b1, k_sof_word, '0);
                drive_word(1'b0, 1'b0, k_frame_head_flag[31:16], '0);
                drive_word(1'b0, 1'b0, k_frame_head_flag[15:0] ^ 16'h0001, '0);
            end
            for (int g = 0; g < e.gap; g++) begin
                if (e.link_word && (g == 2 || g == 6)) begin
                    drive_word(1'b1, 1'b1, k_link_loss_word,
                               rx_loss_t'{link_loss: e.link_pulse && g == 2, sync_loss: 1'b0});
                end else begin
                    drive_filler();
                end
            end

            type_word = {e.file_end, e.channel_id, e.data_type, e.line_number[23:16]};
            n_words   = e.unit ? e.data_length : (e.data_length + 16'd1) >> 1;
            drive_word(1'b0, 1'b1, k_sync_word, '0);
            drive_word(1'b1, 1'b1, k_sof_word, '0);
            drive_word(1'b0, 1'b0, k_frame_head_flag[31:16], '0);
            drive_word(1'b0, 1'b0, k_frame_head_flag[15:0], '0);
            drive_word(1'b0, 1'b0, type_word, '0);
            drive_word(1'b0, 1'b0, e.line_number[15:0], '0);
            drive_word(1'b0, 1'b0, e.data_length, '0);
            sum = type_word + e.line_number[15:0] + e.data_length;

            for (int w = 0; w < n_words; w++) begin
                word           = 16'($urandom);
                sum            = sum + word;
                word_exp.valid = 1'b1;
                word_exp.last  = (w == n_words - 1);
                word_exp.data  = word;
                exp_q.push_back(word_exp);
                if (w == e.k_at_a) begin
                    drive_word(1'b0, 1'b1, word,
                               rx_loss_t'{link_loss: 1'b0, sync_loss: e.k_pulse_a});
                end else if (w == e.k_at_b) begin
                    drive_word(1'b0, 1'b1, word,
                               rx_loss_t'{link_loss: 1'b0, sync_loss: e.k_pulse_b});
                end else begin
                    drive_word(1'b0, 1'b0, word, '0);
                end
            end
            drive_word(1'b0, 1'b0, e.corrupt ? sum + 16'd1 : sum, '0);

            wait_frame_done(res);
            check_result(res, rx_frame_result_t'{done: 1'b1, checksum_err: e.corrupt});
            hdr_exp.file_end    = e.file_end;
            hdr_exp.channel_id  = e.channel_id;
            hdr_exp.data_type   = e.data_type;
            hdr_exp.line_number = e.line_number;
            hdr_exp.data_length = e.data_length;
            check_header(header, hdr_exp);
            if (exp_q.size() != 0) begin
                stop_with_failure("payload words were missing at the end of a frame");
            end
            prev_corrupt = e.corrupt;
        end

        repeat (4) drive_filler();
        @(negedge rx_clk);
        if (done_count != n_frames || exp_q.size() != 0) begin
            stop_with_failure("frame done count or payload count is wrong at the end of the run");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

// File: vlog.f
+incdir+tb
common/tlk2711_rx_pkg.sv
src/rx_frame_fsm.sv
src/rx_payload_counter.sv
src/rx_frame_capture.sv
src/rx_loss_monitor.sv
src/tlk2711_rx_link.sv
tb/tb_tlk2711_rx_link.sv

// File: Bender.yml
package:
  name: tlk2711_rx_link

sources:
  - common/tlk2711_rx_pkg.sv
  - src/rx_frame_fsm.sv
  - src/rx_payload_counter.sv
  - src/rx_frame_capture.sv
  - src/rx_loss_monitor.sv
  - src/tlk2711_rx_link.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_tlk2711_rx_link.sv
